//--- rtl/tg_settings.svh
`ifndef TG_SETTINGS_SVH
`define TG_SETTINGS_SVH

// stream fifo geometry
`define TG_FIFO_DEPTH 16
`define TG_FIFO_DEPTHBITS 4

// notfull drops here, two entries short of the top, so a producer
// that reacts to the registered level still lands inside the array
`define TG_FIFO_FULL_LEVEL 14

// payload fields
`define TG_DATA_W 32 // beat data
`define TG_LEN_W 8   // beats per command

// statistics
`define TG_CNT_W 16

`endif

//--- rtl/tg_pkg.sv
`include "tg_settings.svh"

package tg_pkg;

  // how the beat data of one packet is formed
  typedef enum logic {
    PAT_INCR  = 1'b0, // seed + beat index
    PAT_CONST = 1'b1  // seed on every beat
  } pattern_mode_t;

  // one generator command, roughly two words wide
  typedef struct packed {
    logic [`TG_DATA_W-1:0] seed;
    logic [`TG_LEN_W-1:0]  len;  // number of beats, zero is illegal
    pattern_mode_t         mode;
  } cmd_t;

  // one output beat
  typedef struct packed {
    logic [`TG_DATA_W-1:0] data;
    logic                  last;
  } beat_t;

endpackage

//--- rtl/stream_fifo.sv
`include "tg_settings.svh"

module stream_fifo
  import tg_pkg::*;
#(
  parameter type payload_t = beat_t
) (
  input  logic                        Clk,
  input  logic                        rst,
  input  logic                        push,
  input  payload_t                    in_data,
  input  logic                        pop,
  output logic                        valid,
  output logic                        notfull,
  output logic                        overflow,
  output logic [`TG_FIFO_DEPTHBITS:0] depth,
  output payload_t                    out_data
);

  payload_t mem [`TG_FIFO_DEPTH];
  payload_t head_q;
  payload_t head_nxt;

  logic [`TG_FIFO_DEPTHBITS-1:0] wr_ptr_q;
  logic [`TG_FIFO_DEPTHBITS-1:0] rd_ptr_q;
  logic [`TG_FIFO_DEPTHBITS:0]   depth_q;
  logic [`TG_FIFO_DEPTHBITS:0]   depth_nxt;
  logic                          valid_q;
  logic                          notfull_q;
  logic                          head_from_input;

  // occupancy after this edge, head register included
  always_comb begin
    depth_nxt = depth_q;
    if (push && !pop) begin
      depth_nxt = depth_q + 1'b1;
    end else if (!push && pop) begin
      depth_nxt = depth_q - 1'b1;
    end
  end

  // the incoming word goes straight to the head when nothing sits behind it
  assign head_from_input = push &&
                           ((depth_q == '0) || ((depth_q == 1) && pop));

  always_comb begin
    head_nxt = head_q;
    if (head_from_input) begin
      head_nxt = in_data;
    end else if (pop && (depth_q > 1)) begin
      head_nxt = mem[rd_ptr_q]; // next word behind the head
    end
  end

  always_ff @(posedge Clk) begin
    if (rst) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= `TG_FIFO_DEPTHBITS'(1); // slot 0 is shadowed by the head
      depth_q   <= '0;
      valid_q   <= 1'b0;
      notfull_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      depth_q   <= depth_nxt;
      valid_q   <= (depth_nxt != '0);
      notfull_q <= (depth_nxt < `TG_FIFO_FULL_LEVEL);
    end
  end

  always_ff @(posedge Clk) begin
    if (push) begin
      mem[wr_ptr_q] <= in_data;
    end
    head_q <= head_nxt;
  end

  assign out_data = head_q; // holds its last value once empty
  assign valid    = valid_q;
  assign notfull  = notfull_q;
  assign overflow = depth_q[`TG_FIFO_DEPTHBITS];
  assign depth    = depth_q;

endmodule

//--- rtl/cmd_intake.sv
`include "tg_settings.svh"

module cmd_intake
  import tg_pkg::*;
(
  input  logic                 Clk,
  input  logic                 rst,
  input  logic                 cmd_push,
  input  cmd_t                 cmd,
  input  logic                 pop,
  output logic                 cmd_ready,
  output logic                 cmd_valid,
  output cmd_t                 head,
  output logic [`TG_CNT_W-1:0] reject_count,
  output logic [`TG_CNT_W-1:0] drop_count
);

  logic fifo_notfull;
  logic drop_hit;
  logic reject_hit;
  logic accept;

  // drop test first, a zero-length push into a full queue is only a drop
  assign drop_hit   = cmd_push && !fifo_notfull;
  assign reject_hit = cmd_push && fifo_notfull && (cmd.len == '0);
  assign accept     = cmd_push && fifo_notfull && (cmd.len != '0);

  stream_fifo #(
    .payload_t(cmd_t)
  ) u_cmd_fifo (
    .Clk     (Clk),
    .rst     (rst),
    .push    (accept),
    .in_data (cmd),
    .pop     (pop),
    .valid   (cmd_valid),
    .notfull (fifo_notfull),
    .overflow(),
    .depth   (),
    .out_data(head)
  );

  always_ff @(posedge Clk) begin
    if (rst) begin
      reject_count <= '0;
      drop_count   <= '0;
    end else begin
      if (reject_hit && (reject_count != '1)) begin
        reject_count <= reject_count + 1'b1;
      end
      if (drop_hit && (drop_count != '1)) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

  assign cmd_ready = fifo_notfull;

endmodule

//--- rtl/beat_generator.sv
`include "tg_settings.svh"

module beat_generator
  import tg_pkg::*;
(
  input  logic  Clk,
  input  logic  rst,
  input  logic  cmd_valid,
  input  cmd_t  head,
  input  logic  beat_notfull,
  output logic  pop,
  output logic  beat_push,
  output beat_t beat
);

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_EMIT = 1'b1
  } gen_state_t;

  gen_state_t state_q;

  logic [`TG_DATA_W-1:0] seed_q;
  logic [`TG_LEN_W-1:0]  remain_q; // beats still to emit
  logic [`TG_LEN_W-1:0]  index_q;  // beat position within the packet
  pattern_mode_t         mode_q;
  logic                  last_beat;

  // take the head command only from idle
  assign pop = (state_q == ST_IDLE) && cmd_valid;

  // notfull already leaves room for the beat in flight
  assign beat_push = (state_q == ST_EMIT) && beat_notfull;

  assign last_beat = (remain_q == `TG_LEN_W'(1));

  always_ff @(posedge Clk) begin
    if (rst) begin
      state_q  <= ST_IDLE;
      remain_q <= '0;
      index_q  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (pop) begin
            remain_q <= head.len;
            index_q  <= '0;
            state_q  <= ST_EMIT;
          end
        end
        ST_EMIT: begin
          if (beat_push) begin
            remain_q <= remain_q - 1'b1;
            index_q  <= index_q + 1'b1;
            if (last_beat) begin
              state_q <= ST_IDLE; // one bubble before the next command
            end
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // command payload, loaded together with the count
  always_ff @(posedge Clk) begin
    if (pop) begin
      seed_q <= head.seed;
      mode_q <= head.mode;
    end
  end

  always_comb begin
    beat.last = last_beat;
    if (mode_q == PAT_INCR) begin
      beat.data = seed_q + `TG_DATA_W'(index_q);
    end else begin
      beat.data = seed_q;
    end
  end

endmodule

//--- rtl/stream_output.sv
`include "tg_settings.svh"

module stream_output
  import tg_pkg::*;
(
  input  logic                 Clk,
  input  logic                 rst,
  input  logic                 beat_push,
  input  beat_t                beat,
  input  logic                 out_ready,
  output logic                 beat_notfull,
  output logic                 out_valid,
  output beat_t                out_beat,
  output logic [`TG_CNT_W-1:0] packet_count
);

  logic take; // one transfer on the output stream

  assign take = out_valid && out_ready;

  stream_fifo #(
    .payload_t(beat_t)
  ) u_beat_fifo (
    .Clk     (Clk),
    .rst     (rst),
    .push    (beat_push),
    .in_data (beat),
    .pop     (take),
    .valid   (out_valid),
    .notfull (beat_notfull),
    .overflow(),
    .depth   (),
    .out_data(out_beat)
  );

  // one packet per transfer that carries last
  always_ff @(posedge Clk) begin
    if (rst) begin
      packet_count <= '0;
    end else if (take && out_beat.last) begin
      packet_count <= packet_count + 1'b1;
    end
  end

endmodule

//--- rtl/traffic_gen_top.sv
`include "tg_settings.svh"

module traffic_gen_top
  import tg_pkg::*;
(
  input  logic                 Clk,
  input  logic                 rst,
  input  logic                 cmd_push,
  input  cmd_t                 cmd,
  output logic                 cmd_ready,
  input  logic                 out_ready,
  output logic                 out_valid,
  output beat_t                out_beat,
  output logic [`TG_CNT_W-1:0] reject_count,
  output logic [`TG_CNT_W-1:0] drop_count,
  output logic [`TG_CNT_W-1:0] packet_count
);

  // command queue to generator
  logic  cmd_valid;
  cmd_t  head;
  logic  pop;

  // generator to beat buffer
  logic  beat_push;
  beat_t beat;
  logic  beat_notfull;

  cmd_intake u_cmd_intake (
    .Clk         (Clk),
    .rst         (rst),
    .cmd_push    (cmd_push),
    .cmd         (cmd),
    .pop         (pop),
    .cmd_ready   (cmd_ready),
    .cmd_valid   (cmd_valid),
    .head        (head),
    .reject_count(reject_count),
    .drop_count  (drop_count)
  );

  beat_generator u_beat_generator (
    .Clk         (Clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .head        (head),
    .beat_notfull(beat_notfull),
    .pop         (pop),
    .beat_push   (beat_push),
    .beat        (beat)
  );

  stream_output u_stream_output (
    .Clk         (Clk),
    .rst         (rst),
    .beat_push   (beat_push),
    .beat        (beat),
    .out_ready   (out_ready),
    .beat_notfull(beat_notfull),
    .out_valid   (out_valid),
    .out_beat    (out_beat),
    .packet_count(packet_count)
  );

endmodule

//--- tb/traffic_gen_assertions.sv
module traffic_gen_assertions
  import tg_pkg::*;
(
  input logic  Clk,
  input logic  rst,
  input logic  out_valid,
  input logic  out_ready,
  input beat_t out_beat,
  input logic  cmd_overflow,
  input logic  beat_overflow
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0; // picked up by the testbench for its verdict

  // a beat on offer stays put until the sink takes it
  hold_check: assert property (@(posedge Clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
  else begin
    fail_count++;
    $error("out_beat changed or out_valid fell before the beat was taken");
  end

  // full level of 14 keeps both buffers short of the array size
  overflow_check: assert property (@(posedge Clk) disable iff (rst)
    !(cmd_overflow || beat_overflow))
  else begin
    fail_count++;
    $error("fifo overflow bit set, cmd %b beat %b", cmd_overflow, beat_overflow);
  end

  reset_check: assert property (@(posedge Clk) rst |=> !out_valid)
  else begin
    fail_count++;
    $error("out_valid high right after a reset cycle");
  end

endmodule

bind traffic_gen_top traffic_gen_assertions protocol_checks (
  .Clk          (Clk),
  .rst          (rst),
  .out_valid    (out_valid),
  .out_ready    (out_ready),
  .out_beat     (out_beat),
  .cmd_overflow (u_cmd_intake.u_cmd_fifo.overflow),
  .beat_overflow(u_stream_output.u_beat_fifo.overflow)
);

//--- tb/traffic_gen_tb.sv
`include "tg_settings.svh"

module traffic_gen_tb
  import tg_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD     = 50;
  localparam int TEST_CYCLES     = 3000; // all phases together stay well below this
  localparam int MARGIN_CYCLES   = 1000;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + MARGIN_CYCLES;
  localparam int DRAIN_LIMIT     = 800;

  typedef enum int {READY_LOW, READY_HIGH, READY_RANDOM} ready_mode_t;

  logic                 Clk = 1'b0;
  logic                 rst;
  logic                 cmd_push;
  cmd_t                 cmd;
  logic                 cmd_ready;
  logic                 out_ready;
  logic                 out_valid;
  beat_t                out_beat;
  logic [`TG_CNT_W-1:0] reject_count;
  logic [`TG_CNT_W-1:0] drop_count;
  logic [`TG_CNT_W-1:0] packet_count;

  // reference model state
  beat_t                exp_q[$];
  beat_t                exp_head = '0;
  logic                 exp_empty = 1'b1;
  logic [`TG_CNT_W-1:0] exp_reject = '0;
  logic [`TG_CNT_W-1:0] exp_drop = '0;
  logic [`TG_CNT_W-1:0] exp_packet = '0;

  int          errors = 0;
  int          transfers = 0;
  integer      seed;
  string       test_name = "reset";
  ready_mode_t ready_mode = READY_LOW;
  ready_mode_t ready_now;
  logic [31:0] ready_rnd;
  logic        fill_phase = 1'b0; // set once the command queue is meant to fill

  traffic_gen_top traffic_gen_top_inst (
    .Clk(Clk), .rst(rst), .cmd_push(cmd_push), .cmd(cmd), .cmd_ready(cmd_ready),
    .out_ready(out_ready), .out_valid(out_valid), .out_beat(out_beat),
    .reject_count(reject_count), .drop_count(drop_count), .packet_count(packet_count)
  );

  always #HALF_PERIOD Clk = ~Clk;

  // sink side, mode and random draw taken at the edge, applied 5 ns later
  always @(posedge Clk) begin
    ready_now = ready_mode;
    ready_rnd = $random(seed);
    #5;
    case (ready_now)
      READY_HIGH:   out_ready = 1'b1;
      READY_RANDOM: out_ready = ready_rnd[0];
      default:      out_ready = 1'b0;
    endcase
  end

  function automatic beat_t expected_beat(cmd_t c, int i);
    beat_t b;
    b.data = (c.mode == PAT_INCR) ? c.seed + `TG_DATA_W'(i) : c.seed;
    b.last = (i == int'(c.len) - 1);
    return b;
  endfunction

  always @(posedge Clk) begin
    if (rst) begin
      exp_q.delete();
      exp_reject = '0;
      exp_drop   = '0;
      exp_packet = '0;
    end else begin
      if (out_valid && out_ready) begin
        transfers++;
        if (exp_q.size() != 0) begin
          if (exp_q[0].last) exp_packet = exp_packet + 1'b1;
          exp_q.delete(0);
        end
      end
      if (cmd_push && !cmd_ready) begin
        exp_drop = exp_drop + 1'b1; // drop wins over the length test
      end else if (cmd_push && (cmd.len == '0)) begin
        exp_reject = exp_reject + 1'b1;
      end else if (cmd_push) begin
        for (int i = 0; i < int'(cmd.len); i++) exp_q.push_back(expected_beat(cmd, i));
      end
    end
    exp_empty = (exp_q.size() == 0);
    if (!exp_empty) exp_head = exp_q[0];
  end

  beat_check: assert property (@(posedge Clk) disable iff (rst)
    (out_valid && out_ready) |-> (!exp_empty && (out_beat == exp_head)))
  else begin
    errors++;
    $display("FAIL %s: expected %h actual %h", test_name, $sampled(exp_head),
             $sampled(out_beat));
  end

  packet_check: assert property (@(posedge Clk) disable iff (rst) packet_count == exp_packet)
  else begin
    errors++;
    $display("FAIL %s: expected packets %0d actual %0d", test_name, $sampled(exp_packet),
             $sampled(packet_count));
  end

  reject_check: assert property (@(posedge Clk) disable iff (rst) reject_count == exp_reject)
  else begin
    errors++;
    $display("FAIL %s: expected rejects %0d actual %0d", test_name, $sampled(exp_reject),
             $sampled(reject_count));
  end

  drop_check: assert property (@(posedge Clk) disable iff (rst) drop_count == exp_drop)
  else begin
    errors++;
    $display("FAIL %s: expected drops %0d actual %0d", test_name, $sampled(exp_drop),
             $sampled(drop_count));
  end

  // outside the full queue test the command queue never fills
  ready_check: assert property (@(posedge Clk) disable iff (rst)
    (cmd_push && !fill_phase) |-> cmd_ready)
  else begin
    errors++;
    $display("FAIL %s: expected cmd_ready 1 actual %b", test_name, $sampled(cmd_ready));
  end

  reset_check: assert property (@(posedge Clk) rst |=> (!out_valid && !cmd_ready &&
    (packet_count == '0) && (reject_count == '0) && (drop_count == '0)))
  else begin
    errors++;
    $display("FAIL %s: expected 0 actual valid %b ready %b counts %0d/%0d/%0d", test_name,
             $sampled(out_valid), $sampled(cmd_ready), $sampled(packet_count),
             $sampled(reject_count), $sampled(drop_count));
  end

  task automatic next_cycle();
    @(posedge Clk);
    #5;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic push_cmd(input logic [31:0] s, input logic [`TG_LEN_W-1:0] len,
                          input pattern_mode_t mode);
    cmd_push = 1'b1;
    cmd.seed = s;
    cmd.len  = len;
    cmd.mode = mode;
    next_cycle();
    cmd_push = 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while ((exp_q.size() != 0) && (n < limit)) begin
      next_cycle();
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%s: %0d beats still missing after %0d cycles", test_name, exp_q.size(), limit);
    end
  endtask

  function automatic int pattern_len(int k);
    case (k)
      0:       return 1;
      1:       return 2;
      default: return 37;
    endcase
  endfunction

  initial begin
    #(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
    $display("watchdog: run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    int          n;
    int          fails;
    seed      = 32'hab2f_fd06;
    rst       = 1'b1;
    cmd_push  = 1'b0;
    cmd       = '0;
    out_ready = 1'b0;
    repeat (3) @(posedge Clk);
    #5;
    rst = 1'b0;
    idle_cycles(4);

    test_name  = "patterns";
    ready_mode = READY_HIGH;
    for (int m = 0; m < 2; m++) begin
      for (int k = 0; k < 3; k++) begin
        push_cmd($random(seed), `TG_LEN_W'(pattern_len(k)), pattern_mode_t'(m));
        wait_drain(DRAIN_LIMIT);
      end
    end
    push_cmd(32'hffff_fff0, 8'd37, PAT_INCR); // data wraps past the top
    wait_drain(DRAIN_LIMIT);

    test_name = "order";
    for (int k = 0; k < 5; k++) begin
      rnd = $random(seed);
      push_cmd($random(seed), `TG_LEN_W'(rnd[2:0]) + 1'b1, pattern_mode_t'(k % 2));
    end
    wait_drain(DRAIN_LIMIT);

    test_name = "zero_length";
    push_cmd($random(seed), 8'd0, PAT_INCR);
    push_cmd($random(seed), 8'd3, PAT_INCR);
    push_cmd($random(seed), 8'd0, PAT_CONST);
    push_cmd($random(seed), 8'd0, PAT_INCR);
    wait_drain(DRAIN_LIMIT);
    idle_cycles(3);

    test_name  = "backpressure";
    ready_mode = READY_RANDOM;
    for (int k = 0; k < 10; k++) begin
      rnd = $random(seed);
      n   = int'(rnd[4:0]) % 24 + 1;
      push_cmd($random(seed), `TG_LEN_W'(n), pattern_mode_t'(rnd[5]));
      idle_cycles(int'(rnd[7:6]));
    end
    wait_drain(DRAIN_LIMIT);

    test_name  = "full_queue";
    ready_mode = READY_LOW;
    fill_phase = 1'b1;
    idle_cycles(2);
    n = 0;
    while (cmd_ready && (n < 40)) begin
      push_cmd($random(seed), 8'd4, PAT_INCR);
      n++;
    end
    if (cmd_ready) begin
      errors++;
      $display("full_queue: cmd_ready still high after %0d pushes", n);
    end
    push_cmd($random(seed), 8'd4, PAT_CONST);
    push_cmd($random(seed), 8'd0, PAT_INCR); // counts as a drop only
    push_cmd($random(seed), 8'd6, PAT_INCR);
    idle_cycles(2);
    ready_mode = READY_HIGH;
    wait_drain(DRAIN_LIMIT);
    idle_cycles(4);

    fails = errors + int'(traffic_gen_top_inst.protocol_checks.fail_count);
    $display("closing: %0d errors, %0d protocol failures, %0d transfers, %0d packets",
             errors, traffic_gen_top_inst.protocol_checks.fail_count, transfers, exp_packet);
    if (fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+rtl
rtl/tg_pkg.sv
rtl/stream_fifo.sv
rtl/cmd_intake.sv
rtl/beat_generator.sv
rtl/stream_output.sv
rtl/traffic_gen_top.sv
tb/traffic_gen_assertions.sv
tb/traffic_gen_tb.sv

//--- run.sh
#!/bin/sh
# build and run the traffic generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module traffic_gen_tb -Mdir obj_dir -f all.f || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/Vtraffic_gen_tb +verilator+error+limit+1000)
echo "$sim_out"
echo "$sim_out" | grep -qx "TESTS PASSED" && echo "run passed" || { echo "run failed"; exit 1; }
